// ==== source/rng_pkg.sv ====
// Shared widths, generator reset seeds, register map enum and bus state enum
package rng_pkg;

    // ======================================================================
    // Datapath widths
    // ======================================================================
    // One generated output value
    localparam int RNG_W   = 16;
    // One xorshift128 state word
    localparam int STATE_W = 32;

    // ======================================================================
    // Generator state after reset
    // ======================================================================
    localparam logic [STATE_W-1:0] SEED_X_RST = 32'h12345678;
    localparam logic [STATE_W-1:0] SEED_Y_RST = 32'h9ABCDEF0;
    localparam logic [STATE_W-1:0] SEED_Z_RST = 32'h13579BDF;
    localparam logic [STATE_W-1:0] SEED_W_RST = 32'h2468ACE0;

    // Word addresses on the Wishbone port
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,  // Bit 0 enable, bit 1 reseed pulse
        REG_SEED0  = 3'd1,  // State word x
        REG_SEED1  = 3'd2,  // State word y
        REG_SEED2  = 3'd3,  // State word z
        REG_SEED3  = 3'd4,  // State word w
        REG_LIMIT  = 3'd5,  // Range limit, 0 disables scaling
        REG_DATA   = 3'd6,  // FIFO head, read pops
        REG_STATUS = 3'd7   // Count, underflow, full, empty
    } rng_reg_e;

    // Slave handshake states
    typedef enum logic {
        BUS_IDLE = 1'b0,
        BUS_ACK  = 1'b1
    } bus_state_e;

endpackage

// ==== source/xorshift_core.sv ====
// Xorshift128 state registers with seed load and single-step advance
`timescale 1ns/1ns

module xorshift_core (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        load_i,
    input  logic                        advance_i,
    input  logic [rng_pkg::STATE_W-1:0] seed_x_i,
    input  logic [rng_pkg::STATE_W-1:0] seed_y_i,
    input  logic [rng_pkg::STATE_W-1:0] seed_z_i,
    input  logic [rng_pkg::STATE_W-1:0] seed_w_i,
    output logic [rng_pkg::RNG_W-1:0]   value_o,
    output logic                        valid_o
);
    import rng_pkg::*;

    logic [STATE_W-1:0] x_q, y_q, z_q, w_q;
    logic [STATE_W-1:0] t;
    logic [STATE_W-1:0] w_next;

    // ======================================================================
    // One xorshift128 step
    // ======================================================================
    always_comb begin
        t      = x_q ^ (x_q << 11);
        w_next = w_q ^ (w_q >> 19) ^ t ^ (t >> 8);
    end

    // State words, load has priority over advance
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            x_q <= SEED_X_RST;
            y_q <= SEED_Y_RST;
            z_q <= SEED_Z_RST;
            w_q <= SEED_W_RST;
        end else if (load_i) begin
            x_q <= seed_x_i;
            y_q <= seed_y_i;
            z_q <= seed_z_i;
            w_q <= seed_w_i;
        end else if (advance_i) begin
            // Words rotate down, new w enters at the top
            x_q <= y_q;
            y_q <= z_q;
            z_q <= w_q;
            w_q <= w_next;
        end
    end

    // Output stage, valid for exactly one cycle per step
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= advance_i && !load_i;
        end
    end

    // Low half of the new w
    always_ff @(posedge clk_i) begin
        if (advance_i) begin
            value_o <= w_next[RNG_W-1:0];
        end
    end

endmodule

// ==== source/range_scaler.sv ====
// Registered multiply-high range reduction stage with valid flag
`timescale 1ns/1ns

module range_scaler (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      flush_i,
    input  logic [rng_pkg::RNG_W-1:0] value_i,
    input  logic                      valid_i,
    input  logic [rng_pkg::RNG_W-1:0] limit_i,
    output logic [rng_pkg::RNG_W-1:0] value_o,
    output logic                      valid_o
);
    import rng_pkg::*;

    logic [2*RNG_W-1:0] product;
    logic [RNG_W-1:0]   scaled;

    // Upper half of value times limit lies in 0 to limit - 1
    always_comb begin
        product = value_i * limit_i;
        scaled  = (limit_i == '0) ? value_i : product[2*RNG_W-1:RNG_W];
    end

    // Flush discards the value arriving from the core
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        value_o <= scaled;
    end

endmodule

// ==== source/rng_fifo.sv ====
// Synchronous output FIFO with fill count and flush
`timescale 1ns/1ns

module rng_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        flush_i,
    input  logic                        push_i,
    input  logic [rng_pkg::RNG_W-1:0]   wdata_i,
    input  logic                        pop_i,
    output logic [rng_pkg::RNG_W-1:0]   rdata_o,
    output logic [$clog2(FIFO_DEPTH):0] count_o,
    output logic                        full_o,
    output logic                        empty_o
);
    import rng_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [RNG_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [AW:0]      count_q;
    logic             do_push;
    logic             do_pop;

    // Guarded handshakes
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            // Occupancy moves only when one side acts alone
            if (do_push && !do_pop) count_q <= count_q + 1'b1;
            else if (do_pop && !do_push) count_q <= count_q - 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge clk_i) begin
        if (do_push) mem[wr_ptr_q] <= wdata_i;
    end

    // Head shown without a read cycle
    assign rdata_o = mem[rd_ptr_q];
    assign count_o = count_q;
    assign full_o  = (count_q == FIFO_DEPTH);
    assign empty_o = (count_q == '0);

endmodule

// ==== source/rng_ctrl.sv ====
// Wishbone slave, register file, reseed decode, generation pacing and FIFO read path
`timescale 1ns/1ns

module rng_ctrl #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    // Wishbone classic slave
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [2:0]                  wb_adr_i,
    input  logic [31:0]                 wb_dat_i,
    output logic [31:0]                 wb_dat_o,
    output logic                        wb_ack_o,
    // Output FIFO state
    input  logic [rng_pkg::RNG_W-1:0]   fifo_rdata_i,
    input  logic [$clog2(FIFO_DEPTH):0] fifo_count_i,
    input  logic                        fifo_full_i,
    input  logic                        fifo_empty_i,
    // Pipeline occupancy
    input  logic                        core_valid_i,
    input  logic                        scale_valid_i,
    // Generator control
    output logic [rng_pkg::STATE_W-1:0] seed_x_o,
    output logic [rng_pkg::STATE_W-1:0] seed_y_o,
    output logic [rng_pkg::STATE_W-1:0] seed_z_o,
    output logic [rng_pkg::STATE_W-1:0] seed_w_o,
    output logic                        load_o,
    output logic                        advance_o,
    output logic [rng_pkg::RNG_W-1:0]   limit_o,
    output logic                        pop_o,
    output logic                        flush_o
);
    import rng_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    bus_state_e           state_q;
    logic                 bus_rd;
    logic                 bus_wr;
    logic                 enable_q;
    logic                 underflow_q;
    logic [STATE_W-1:0]   seed_x_q, seed_y_q, seed_z_q, seed_w_q;
    logic [RNG_W-1:0]     limit_q;
    logic [1:0]           inflight;
    logic [CNT_W:0]       fill_sum;

    // ======================================================================
    // Bus handshake, ack one cycle after the request
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= BUS_IDLE;
        end else begin
            case (state_q)
                // No new request taken in the ack cycle
                BUS_IDLE: if (wb_cyc_i && wb_stb_i) state_q <= BUS_ACK;
                BUS_ACK:  state_q <= BUS_IDLE;
                default:  state_q <= BUS_IDLE;
            endcase
        end
    end

    assign wb_ack_o = (state_q == BUS_ACK);
    // Master holds address and data until ack
    assign bus_rd   = wb_ack_o && !wb_we_i;
    assign bus_wr   = wb_ack_o && wb_we_i;

    // ======================================================================
    // Register file, writes land on the ack edge
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable_q    <= 1'b0;
            underflow_q <= 1'b0;
            seed_x_q    <= SEED_X_RST;
            seed_y_q    <= SEED_Y_RST;
            seed_z_q    <= SEED_Z_RST;
            seed_w_q    <= SEED_W_RST;
            limit_q     <= '0;
        end else begin
            if (bus_wr) begin
                case (rng_reg_e'(wb_adr_i))
                    REG_CTRL:  enable_q <= wb_dat_i[0];
                    REG_SEED0: seed_x_q <= wb_dat_i;
                    REG_SEED1: seed_y_q <= wb_dat_i;
                    REG_SEED2: seed_z_q <= wb_dat_i;
                    REG_SEED3: seed_w_q <= wb_dat_i;
                    REG_LIMIT: limit_q  <= wb_dat_i[RNG_W-1:0];
                    default:   ;
                endcase
            end
            // Sticky until STATUS is read
            if (bus_rd && rng_reg_e'(wb_adr_i) == REG_DATA && fifo_empty_i) begin
                underflow_q <= 1'b1;
            end else if (bus_rd && rng_reg_e'(wb_adr_i) == REG_STATUS) begin
                underflow_q <= 1'b0;
            end
        end
    end

    // Reseed pulse also drops whatever is still in the pipeline
    assign load_o  = bus_wr && (rng_reg_e'(wb_adr_i) == REG_CTRL) && wb_dat_i[1];
    assign flush_o = load_o;
    // Pop only a real head entry
    assign pop_o   = bus_rd && (rng_reg_e'(wb_adr_i) == REG_DATA) && !fifo_empty_i;

    assign seed_x_o = seed_x_q;
    assign seed_y_o = seed_y_q;
    assign seed_z_o = seed_z_q;
    assign seed_w_o = seed_w_q;
    assign limit_o  = limit_q;

    // ======================================================================
    // Generation pacing
    // ======================================================================
    // Values between advance and push, one per pipeline stage
    assign inflight  = {1'b0, core_valid_i} + {1'b0, scale_valid_i};
    assign fill_sum  = (CNT_W+1)'(fifo_count_i) + (CNT_W+1)'(inflight);
    // Load wins inside the core, so no step is issued with it
    assign advance_o = enable_q && !load_o && (fill_sum < FIFO_DEPTH);

    // Read data mux, FIFO head shown as is
    always_comb begin
        case (rng_reg_e'(wb_adr_i))
            REG_CTRL:   wb_dat_o = {31'b0, enable_q};
            REG_SEED0:  wb_dat_o = seed_x_q;
            REG_SEED1:  wb_dat_o = seed_y_q;
            REG_SEED2:  wb_dat_o = seed_z_q;
            REG_SEED3:  wb_dat_o = seed_w_q;
            REG_LIMIT:  wb_dat_o = {16'b0, limit_q};
            REG_DATA:   wb_dat_o = fifo_empty_i ? 32'b0 : {16'b0, fifo_rdata_i};
            REG_STATUS: wb_dat_o = {16'b0, 8'(fifo_count_i), 5'b0,
                                   underflow_q, fifo_full_i, fifo_empty_i};
            default:    wb_dat_o = 32'b0;
        endcase
    end

endmodule

// ==== source/rng_periph_top.sv ====
// Peripheral top level joining control, generator, scaler and output FIFO
`timescale 1ns/1ns

module rng_periph_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        clk_i,
    input  logic        rst_i,
    // Wishbone classic slave
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [2:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);
    import rng_pkg::*;

    // Generator control
    logic [STATE_W-1:0]          seed_x, seed_y, seed_z, seed_w;
    logic                        load, advance;
    logic [RNG_W-1:0]            limit;
    // Datapath between stages
    logic [RNG_W-1:0]            core_value;
    logic                        core_valid;
    logic [RNG_W-1:0]            fifo_wdata;
    logic                        fifo_push;
    // FIFO side
    logic                        fifo_pop, fifo_flush;
    logic [RNG_W-1:0]            fifo_rdata;
    logic [$clog2(FIFO_DEPTH):0] fifo_count;
    logic                        fifo_full, fifo_empty;

    rng_ctrl #(.FIFO_DEPTH(FIFO_DEPTH)) i_rng_ctrl (
        .clk_i, .rst_i,
        .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
        .fifo_rdata_i (fifo_rdata),  .fifo_count_i (fifo_count),
        .fifo_full_i  (fifo_full),   .fifo_empty_i (fifo_empty),
        .core_valid_i (core_valid),  .scale_valid_i (fifo_push),
        .seed_x_o (seed_x), .seed_y_o (seed_y), .seed_z_o (seed_z), .seed_w_o (seed_w),
        .load_o (load), .advance_o (advance), .limit_o (limit),
        .pop_o (fifo_pop), .flush_o (fifo_flush)
    );

    xorshift_core i_xorshift_core (
        .clk_i, .rst_i, .load_i (load), .advance_i (advance),
        .seed_x_i (seed_x), .seed_y_i (seed_y), .seed_z_i (seed_z), .seed_w_i (seed_w),
        .value_o (core_value), .valid_o (core_valid)
    );

    // Scaler valid is the FIFO push
    range_scaler i_range_scaler (
        .clk_i, .rst_i, .flush_i (fifo_flush),
        .value_i (core_value), .valid_i (core_valid), .limit_i (limit),
        .value_o (fifo_wdata), .valid_o (fifo_push)
    );

    rng_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_rng_fifo (
        .clk_i, .rst_i, .flush_i (fifo_flush),
        .push_i (fifo_push), .wdata_i (fifo_wdata), .pop_i (fifo_pop),
        .rdata_o (fifo_rdata), .count_o (fifo_count),
        .full_o (fifo_full), .empty_o (fifo_empty)
    );

endmodule

// ==== sim/rng_checker.sv ====
// Bound assertions on the Wishbone handshake and the FIFO push and pop guards
`timescale 1ns/1ns

module rng_checker (
    input logic clk_i,
    input logic rst_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic push_i,
    input logic pop_i,
    input logic full_i,
    input logic empty_i
);
    // Failed assertions, summed into the final report
    int failures = 0;

    // Ack lasts exactly one cycle
    ack_single_a: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_ack_i |=> !wb_ack_i)
        else begin
            $error("ack high for two cycles in a row");
            failures++;
        end

    // Ack only answers a request
    ack_after_req_a: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
        else begin
            $error("ack without a preceding cyc and stb");
            failures++;
        end

    // Pacing keeps the FIFO from overflowing
    no_push_full_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !(push_i && full_i))
        else begin
            $error("FIFO push while full");
            failures++;
        end

    no_pop_empty_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !(pop_i && empty_i))
        else begin
            $error("FIFO pop while empty");
            failures++;
        end

endmodule

bind rng_periph_top rng_checker i_rng_checker (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_i (wb_ack_o),
    .push_i   (fifo_push),
    .pop_i    (fifo_pop),
    .full_i   (fifo_full),
    .empty_i  (fifo_empty)
);

// ==== sim/rng_monitor.sv ====
// Bus monitor comparing read data at the acknowledge with the expected value
`timescale 1ns/1ns

module rng_monitor (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Observed Wishbone signals
    input  logic                      wb_ack_i,
    input  logic                      wb_we_i,
    input  logic [2:0]                wb_adr_i,
    input  logic [31:0]               wb_dat_i,
    // Expectation for the current read
    input  logic                      exp_valid_i,
    input  logic [31:0]               exp_data_i,
    input  logic [rng_pkg::RNG_W-1:0] bound_i,
    output int                        mismatch_count_o,
    output int                        check_count_o
);
    int mismatches;
    int checks;

    initial begin
        mismatches = 0;
        checks     = 0;
    end

    // ======================================================================
    // Read compare
    // ======================================================================
    // Mid-cycle sample, read data holds for the whole ack cycle
    always @(negedge clk_i) begin
        if (!rst_i && wb_ack_i && !wb_we_i && exp_valid_i) begin
            checks = checks + 1;
            if (wb_dat_i !== exp_data_i) begin
                mismatches = mismatches + 1;
                $display("MISMATCH at %0t ns: address %0d expected %08h actual %08h",
                         $time, wb_adr_i, exp_data_i, wb_dat_i);
            end
            // Scaled values lie in 0 to limit - 1
            if (bound_i != '0 && wb_dat_i >= {16'b0, bound_i}) begin
                mismatches = mismatches + 1;
                $display("MISMATCH at %0t ns: address %0d value %08h not below limit %04h",
                         $time, wb_adr_i, wb_dat_i, bound_i);
            end
        end
    end

    assign mismatch_count_o = mismatches;
    assign check_count_o    = checks;

endmodule

// ==== sim/rng_tb.sv ====
// Testbench top with clock, reset, test file reader, Wishbone driver, reference model and report
`timescale 1ns/1ns

module rng_tb;
    import rng_pkg::*;

    localparam int FIFO_DEPTH  = 8;
    localparam int ACK_TIMEOUT = 20;
    localparam int POLL_LIMIT  = 200;

    logic        clk_i;
    logic        rst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [2:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    // Expected value handed to the monitor with each read
    logic             exp_valid;
    logic [31:0]      exp_data;
    logic [RNG_W-1:0] exp_bound;
    int               mismatches;
    int               checks;
    int               other_errors;
    logic             abort;
    // Reference model state, shadow seeds and limit
    logic [STATE_W-1:0] mx, my, mz, mw;
    logic [STATE_W-1:0] sx, sy, sz, sw;
    logic [RNG_W-1:0]   shadow_limit;
    logic [RNG_W-1:0]   model_limit;

    rng_periph_top #(.FIFO_DEPTH(FIFO_DEPTH)) i_rng_periph_top (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    rng_monitor i_rng_monitor (
        .clk_i (clk_i), .rst_i (rst_i),
        .wb_ack_i (wb_ack_o), .wb_we_i (wb_we_i), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_o),
        .exp_valid_i (exp_valid), .exp_data_i (exp_data), .bound_i (exp_bound),
        .mismatch_count_o (mismatches), .check_count_o (checks)
    );

    // 10 ns clock
    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ======================================================================
    // Reference model, xorshift128 step then optional multiply-high
    // ======================================================================
    task automatic model_next(output logic [RNG_W-1:0] v);
        logic [STATE_W-1:0] t;
        logic [STATE_W-1:0] nw;
        logic [2*RNG_W-1:0] prod;
        t    = mx ^ (mx << 11);
        nw   = mw ^ (mw >> 19) ^ t ^ (t >> 8);
        mx   = my;
        my   = mz;
        mz   = mw;
        mw   = nw;
        prod = nw[RNG_W-1:0] * model_limit;
        v    = (model_limit == '0) ? nw[RNG_W-1:0] : prod[2*RNG_W-1:RNG_W];
    endtask

    // ======================================================================
    // Wishbone master, one classic transfer
    // ======================================================================
    task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                             input logic chk, input logic [31:0] exp_val,
                             input logic [RNG_W-1:0] bound, output logic [31:0] rdat);
        int   waited;
        logic acked;
        waited    = 0;
        acked     = 1'b0;
        rdat      = '0;
        wb_cyc_i  = 1'b1;
        wb_stb_i  = 1'b1;
        wb_we_i   = we;
        wb_adr_i  = adr;
        wb_dat_i  = wdat;
        exp_valid = chk;
        exp_data  = exp_val;
        exp_bound = bound;
        // Ack sampled mid-cycle
        while (!acked && waited < ACK_TIMEOUT) begin
            @(negedge clk_i);
            if (wb_ack_o) begin
                acked = 1'b1;
                rdat  = wb_dat_o;
            end
            waited++;
        end
        // Request held through the ack edge
        @(posedge clk_i);
        #1;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        exp_valid = 1'b0;
        if (!acked) begin
            $display("ERROR at %0t ns: no acknowledge from DUT, address %0d", $time, adr);
            other_errors++;
            abort = 1'b1;
        end
    endtask

    // Write plus shadow copy, reseed reloads the model
    task automatic apply_write(input logic [2:0] adr, input logic [31:0] val);
        logic [31:0] rd;
        bus_cycle(1'b1, adr, val, 1'b0, '0, '0, rd);
        case (rng_reg_e'(adr))
            REG_SEED0: sx = val;
            REG_SEED1: sy = val;
            REG_SEED2: sz = val;
            REG_SEED3: sw = val;
            REG_LIMIT: shadow_limit = val[RNG_W-1:0];
            REG_CTRL: begin
                if (val[1]) begin
                    mx          = sx;
                    my          = sy;
                    mz          = sz;
                    mw          = sw;
                    model_limit = shadow_limit;
                end
            end
            default: ;
        endcase
    endtask

    // Poll until every bit of mask is set in the register
    task automatic wait_bits(input logic [2:0] adr, input logic [31:0] mask);
        logic [31:0] rd;
        int          tries;
        tries = 0;
        rd    = '0;
        while (!abort && (rd & mask) != mask && tries < POLL_LIMIT) begin
            bus_cycle(1'b0, adr, '0, 1'b0, '0, '0, rd);
            tries++;
        end
        if (!abort && (rd & mask) != mask) begin
            $display("ERROR at %0t ns: register %0d never showed bits %08h", $time, adr, mask);
            other_errors++;
            abort = 1'b1;
        end
    endtask

    // Poll STATUS until the empty bit drops
    task automatic wait_nonempty();
        logic [31:0] st;
        int          tries;
        tries = 0;
        st    = 32'h1;
        while (!abort && st[0] && tries < POLL_LIMIT) begin
            bus_cycle(1'b0, REG_STATUS, '0, 1'b0, '0, '0, st);
            tries++;
        end
        if (!abort && st[0]) begin
            $display("ERROR at %0t ns: FIFO stayed empty while polling STATUS", $time);
            other_errors++;
            abort = 1'b1;
        end
    endtask

    // Next generated value, checked against the model
    task automatic read_generated(input logic [2:0] adr);
        logic [RNG_W-1:0] v;
        logic [31:0]      rd;
        wait_nonempty();
        if (!abort) begin
            model_next(v);
            bus_cycle(1'b0, adr, '0, 1'b1, {16'b0, v}, model_limit, rd);
        end
    endtask

    // Read DATA until STATUS shows empty
    task automatic drain_fifo(input logic [2:0] adr);
        logic [RNG_W-1:0] v;
        logic [31:0]      st;
        logic [31:0]      rd;
        int               i;
        logic             done;
        done = 1'b0;
        for (i = 0; i < POLL_LIMIT && !abort && !done; i++) begin
            bus_cycle(1'b0, REG_STATUS, '0, 1'b0, '0, '0, st);
            if (st[0]) begin
                done = 1'b1;
            end else if (!abort) begin
                model_next(v);
                bus_cycle(1'b0, adr, '0, 1'b1, {16'b0, v}, model_limit, rd);
            end
        end
        if (!abort && !done) begin
            $display("ERROR at %0t ns: FIFO did not drain", $time);
            other_errors++;
            abort = 1'b1;
        end
    endtask

    // One line of the test file
    task automatic run_line(input logic [7:0] op, input logic [2:0] adr, input logic [31:0] val);
        logic [RNG_W-1:0] v;
        logic [31:0]      rd;
        int               i;
        case (op)
            "W": apply_write(adr, val);
            "R": bus_cycle(1'b0, adr, '0, 1'b1, val, '0, rd);
            "S": wait_bits(adr, val);
            "D": drain_fifo(adr);
            "G": begin
                for (i = 0; i < val && !abort; i++) read_generated(adr);
            end
            "P": begin
                // Fixed value from the file, model kept in step
                wait_nonempty();
                if (!abort) begin
                    model_next(v);
                    bus_cycle(1'b0, adr, '0, 1'b1, val, model_limit, rd);
                end
            end
            default: begin
                $display("ERROR: unknown operation %c in test file", op);
                other_errors++;
            end
        endcase
    endtask

    task automatic report_and_finish();
        int assert_fails;
        int total;
        assert_fails = i_rng_periph_top.i_rng_checker.failures;
        if (checks == 0) begin
            $display("ERROR: no read data was checked");
            other_errors++;
        end
        total = mismatches + assert_fails + other_errors;
        $display("Checks %0d, mismatches %0d, assertion failures %0d, other errors %0d",
                 checks, mismatches, assert_fails, other_errors);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin : main_seq
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] adr_f;
        logic [31:0] val_f;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        exp_valid    = 1'b0;
        exp_data     = '0;
        exp_bound    = '0;
        other_errors = 0;
        abort        = 1'b0;
        // Model starts from the reset seeds
        mx = SEED_X_RST;
        my = SEED_Y_RST;
        mz = SEED_Z_RST;
        mw = SEED_W_RST;
        sx = SEED_X_RST;
        sy = SEED_Y_RST;
        sz = SEED_Z_RST;
        sw = SEED_W_RST;
        shadow_limit = '0;
        model_limit  = '0;
        rst_i        = 1'b1;
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        fd = $fopen("sim/rng_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open test data file sim/rng_tests.txt");
            other_errors++;
        end else begin
            while (!abort && !$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", op, adr_f, val_f);
                    if (n == 3) begin
                        run_line(op, adr_f[2:0], val_f);
                    end else begin
                        $display("ERROR: malformed line in test data file: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        report_and_finish();
    end

endmodule

// ==== sim/rng_tests.txt ====
# Columns: op addr value, addr and value in hex
# W write, R read and expect, P poll then read and expect, G read value words vs model
# S poll addr until value bits set, D drain DATA vs model until STATUS empty
# Reset state
R 7 00000001
R 0 00000000
R 1 12345678
R 4 2468ACE0
R 5 00000000
# First outputs from the reset seeds
W 0 00000001
R 0 00000001
P 6 0000B983
G 6 00000005
# Back-pressure, FIFO fills without reads
S 7 00000002
R 7 00000802
G 6 0000000C
# Underflow after disable and drain
W 0 00000000
R 0 00000000
D 6 00000000
R 6 00000000
R 7 00000005
R 7 00000001
# Written seeds, reseed and enable
W 1 DEADBEEF
W 2 01234567
W 3 89ABCDEF
W 4 CAFEF00D
W 0 00000003
R 7 00000001
G 6 00000018
# Range scaling, limit set before reseed
W 5 00000064
W 0 00000003
G 6 00000018
# Limit zero gives raw values again
W 5 00000000
W 0 00000003
G 6 00000014
# Reseed in mid-run flushes the FIFO
S 7 00000002
W 1 0BADCAFE
W 2 13572468
W 3 600DF00D
W 4 0F1E2D3C
W 0 00000003
R 7 00000001
G 6 00000014
W 0 00000000

// ==== list.f ====
source/rng_pkg.sv
source/xorshift_core.sv
source/range_scaler.sv
source/rng_fifo.sv
source/rng_ctrl.sv
source/rng_periph_top.sv
sim/rng_checker.sv
sim/rng_monitor.sv
sim/rng_tb.sv

// ==== Bender.yml ====
package:
  name: rng_periph

sources:
  # Package first, then leaf modules, then the top level
  - source/rng_pkg.sv
  - source/xorshift_core.sv
  - source/range_scaler.sv
  - source/rng_fifo.sv
  - source/rng_ctrl.sv
  - source/rng_periph_top.sv

  - target: simulation
    files:
      - sim/rng_checker.sv
      - sim/rng_monitor.sv
      - sim/rng_tb.sv
